// ==== src/gnn_bus_cfg.svh ====
// gnn request bus configuration for PE count, field widths and table depth
`ifndef GNN_BUS_CFG_SVH
`define GNN_BUS_CFG_SVH

// number of edge PEs on the request bus
`define GNN_NUM_PE 4

// node id width, also the table address width
`define GNN_NODE_W 6

// PE tag width, enough to name every PE
`define GNN_TAG_W 2

// width of one neighbor or feature table word
`define GNN_DATA_W 16

// table entries, one per node id
`define GNN_TABLE_DEPTH 64

`endif

// ==== src/gnn_bus_pkg.sv ====
// gnn request bus package with the request kind and the bus field types
`include "gnn_bus_cfg.svh"

package gnn_bus_pkg;

    // which lookup a PE asks for
    typedef enum logic {
        kind_neighbor = 1'b0,
        kind_feature  = 1'b1
    } req_kind_e;

    // node id carried with each request
    typedef logic [`GNN_NODE_W-1:0] node_id_t;

    // tag of the requesting PE
    typedef logic [`GNN_TAG_W-1:0] pe_tag_t;

    // one table word as returned to the PE
    typedef logic [`GNN_DATA_W-1:0] info_data_t;

endpackage

// ==== src/rr_arbiter.sv ====
// round-robin arbiter with a registered one-hot grant and rotating priority
`timescale 1ns/1ps
`include "gnn_bus_cfg.svh"

module rr_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`GNN_NUM_PE-1:0] reqs,
    output logic [`GNN_NUM_PE-1:0] grants
);

    localparam int NUM_PE = `GNN_NUM_PE;
    localparam int PTR_W  = $clog2(NUM_PE);

    // highest priority PE for the next search
    logic [PTR_W-1:0]  ptr;
    logic [NUM_PE-1:0] eligible;
    logic [NUM_PE-1:0] next_grants;
    logic [PTR_W-1:0]  winner;
    logic              found;

    // PE holding the grant this cycle sits out the next search
    assign eligible = reqs & ~grants;

    // search upward from the pointer and wrap around
    always_comb begin
        int cand;
        next_grants = '0;
        winner      = ptr;
        found       = 1'b0;
        for (int k = 0; k < NUM_PE; k++) begin
            cand = (int'(ptr) + k) % NUM_PE;
            // first eligible PE wins
            if (!found && eligible[cand]) begin
                found             = 1'b1;
                winner            = PTR_W'(cand);
                next_grants[cand] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grants <= '0;
            ptr    <= '0;
        end else begin
            grants <= next_grants;
            // priority moves to the PE above the winner
            if (found) begin
                if (winner == PTR_W'(NUM_PE - 1)) begin
                    ptr <= '0;
                end else begin
                    ptr <= winner + 1'b1;
                end
            end
        end
    end

    // at most one PE granted at a time
    grants_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grants));

    // grant only to a PE that was requesting one edge earlier
    grant_had_req: assert property (@(posedge clk) disable iff (reset)
        |grants |-> ((grants & $past(reqs)) == grants));

endmodule

// ==== src/bus_arbiter.sv ====
// bus arbiter latching PE requests and routing the granted one by lookup kind
`timescale 1ns/1ps
`include "gnn_bus_cfg.svh"

module bus_arbiter (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                    [`GNN_NUM_PE-1:0] req,
    input  gnn_bus_pkg::req_kind_e  [`GNN_NUM_PE-1:0] req_kind,
    input  gnn_bus_pkg::node_id_t   [`GNN_NUM_PE-1:0] req_node,
    input  gnn_bus_pkg::pe_tag_t    [`GNN_NUM_PE-1:0] req_tag,
    output logic                    [`GNN_NUM_PE-1:0] grant,
    output logic                                      nbr_valid,
    output gnn_bus_pkg::node_id_t                     nbr_node,
    output gnn_bus_pkg::pe_tag_t                      nbr_tag,
    output logic                                      fv_valid,
    output gnn_bus_pkg::node_id_t                     fv_node,
    output gnn_bus_pkg::pe_tag_t                      fv_tag
);

    // request fields as sampled at the grant decision edge
    gnn_bus_pkg::req_kind_e [`GNN_NUM_PE-1:0] kind_q;
    gnn_bus_pkg::node_id_t  [`GNN_NUM_PE-1:0] node_q;
    gnn_bus_pkg::pe_tag_t   [`GNN_NUM_PE-1:0] tag_q;

    // next values of both request channels
    logic                  nbr_valid_d;
    gnn_bus_pkg::node_id_t nbr_node_d;
    gnn_bus_pkg::pe_tag_t  nbr_tag_d;
    logic                  fv_valid_d;
    gnn_bus_pkg::node_id_t fv_node_d;
    gnn_bus_pkg::pe_tag_t  fv_tag_d;

    // grant comes out one cycle after the levels are sampled
    rr_arbiter rr_arbiter_u0 (
        .clk    (clk),
        .reset  (reset),
        .reqs   (req),
        .grants (grant)
    );

    // fields line up with the grant that follows
    always_ff @(posedge clk) begin
        kind_q <= req_kind;
        node_q <= req_node;
        tag_q  <= req_tag;
    end

    // steer the granted request to its channel
    always_comb begin
        nbr_valid_d = 1'b0;
        nbr_node_d  = '0;
        nbr_tag_d   = '0;
        fv_valid_d  = 1'b0;
        fv_node_d   = '0;
        fv_tag_d    = '0;
        for (int i = 0; i < `GNN_NUM_PE; i++) begin
            if (grant[i]) begin
                if (kind_q[i] == gnn_bus_pkg::kind_neighbor) begin
                    nbr_valid_d = 1'b1;
                    nbr_node_d  = node_q[i];
                    nbr_tag_d   = tag_q[i];
                end else begin
                    fv_valid_d = 1'b1;
                    fv_node_d  = node_q[i];
                    fv_tag_d   = tag_q[i];
                end
            end
        end
    end

    // channel strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            nbr_valid <= 1'b0;
            fv_valid  <= 1'b0;
        end else begin
            nbr_valid <= nbr_valid_d;
            fv_valid  <= fv_valid_d;
        end
    end

    // channel payload is zero on the idle channel
    always_ff @(posedge clk) begin
        nbr_node <= nbr_node_d;
        nbr_tag  <= nbr_tag_d;
        fv_node  <= fv_node_d;
        fv_tag   <= fv_tag_d;
    end

    // one request per cycle reaches the memories
    chan_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(nbr_valid && fv_valid));

endmodule

// ==== src/info_mem_cntl.sv ====
// info table controller with an external write port and one tagged read per cycle
`timescale 1ns/1ps
`include "gnn_bus_cfg.svh"

module info_mem_cntl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wr_en,
    input  gnn_bus_pkg::node_id_t  wr_addr,
    input  gnn_bus_pkg::info_data_t wr_data,
    input  logic                   rd_valid,
    input  gnn_bus_pkg::node_id_t  rd_node,
    input  gnn_bus_pkg::pe_tag_t   rd_tag,
    output logic                   rsp_valid,
    output gnn_bus_pkg::info_data_t rsp_data,
    output gnn_bus_pkg::pe_tag_t   rsp_tag
);

    // one word per node id
    gnn_bus_pkg::info_data_t table_mem [`GNN_TABLE_DEPTH];

    // table load from outside
    always_ff @(posedge clk) begin
        if (wr_en) begin
            table_mem[wr_addr] <= wr_data;
        end
    end

    // response strobe trails the read strobe by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_valid;
        end
    end

    // read before write so a same-address write shows up next time
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rsp_data <= table_mem[rd_node];
            // tag goes back with the word
            rsp_tag  <= rd_tag;
        end
    end

endmodule

// ==== src/gnn_bus_top.sv ====
// gnn request bus top joining the arbiter to the neighbor and feature tables
`timescale 1ns/1ps
`include "gnn_bus_cfg.svh"

module gnn_bus_top (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                    [`GNN_NUM_PE-1:0] req,
    input  gnn_bus_pkg::req_kind_e  [`GNN_NUM_PE-1:0] req_kind,
    input  gnn_bus_pkg::node_id_t   [`GNN_NUM_PE-1:0] req_node,
    input  gnn_bus_pkg::pe_tag_t    [`GNN_NUM_PE-1:0] req_tag,
    output logic                    [`GNN_NUM_PE-1:0] grant,
    input  logic                                      nbr_wr_en,
    input  logic                                      fv_wr_en,
    input  gnn_bus_pkg::node_id_t                     wr_addr,
    input  gnn_bus_pkg::info_data_t                   wr_data,
    output logic                                      nbr_rsp_valid,
    output gnn_bus_pkg::info_data_t                   nbr_rsp_data,
    output gnn_bus_pkg::pe_tag_t                      nbr_rsp_tag,
    output logic                                      fv_rsp_valid,
    output gnn_bus_pkg::info_data_t                   fv_rsp_data,
    output gnn_bus_pkg::pe_tag_t                      fv_rsp_tag
);

    // neighbor request channel
    logic                  nbr_valid;
    gnn_bus_pkg::node_id_t nbr_node;
    gnn_bus_pkg::pe_tag_t  nbr_tag;

    // feature request channel
    logic                  fv_valid;
    gnn_bus_pkg::node_id_t fv_node;
    gnn_bus_pkg::pe_tag_t  fv_tag;

    bus_arbiter bus_arb (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_kind  (req_kind),
        .req_node  (req_node),
        .req_tag   (req_tag),
        .grant     (grant),
        .nbr_valid (nbr_valid),
        .nbr_node  (nbr_node),
        .nbr_tag   (nbr_tag),
        .fv_valid  (fv_valid),
        .fv_node   (fv_node),
        .fv_tag    (fv_tag)
    );

    // neighbor info table
    info_mem_cntl nbr_mem (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (nbr_wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_valid  (nbr_valid),
        .rd_node   (nbr_node),
        .rd_tag    (nbr_tag),
        .rsp_valid (nbr_rsp_valid),
        .rsp_data  (nbr_rsp_data),
        .rsp_tag   (nbr_rsp_tag)
    );

    // feature vector table shares the write address and data
    info_mem_cntl fv_mem (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (fv_wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_valid  (fv_valid),
        .rd_node   (fv_node),
        .rd_tag    (fv_tag),
        .rsp_valid (fv_rsp_valid),
        .rsp_data  (fv_rsp_data),
        .rsp_tag   (fv_rsp_tag)
    );

endmodule

// ==== bench/gnn_bus_tb.sv ====
// testbench for the gnn request bus against a model of arbiter and tables
`timescale 1ns/1ps
`include "gnn_bus_cfg.svh"

module gnn_bus_tb;

    localparam int NUM_PE    = `GNN_NUM_PE;
    localparam int DEPTH     = `GNN_TABLE_DEPTH;
    localparam int COLS      = 6;
    localparam int MAX_LINES = 32;

    // line kinds in the tests file
    localparam logic [15:0] OP_LOAD  = 16'h1;
    localparam logic [15:0] OP_REQ   = 16'h2;
    localparam logic [15:0] OP_WRITE = 16'h3;
    localparam logic [15:0] OP_END   = 16'hf;

    // one granted request on its way to a response
    typedef struct packed {
        gnn_bus_pkg::req_kind_e  kind;
        gnn_bus_pkg::node_id_t   node;
        gnn_bus_pkg::pe_tag_t    tag;
        gnn_bus_pkg::info_data_t data;
        int                      due;
    } pend_t;

    logic                                  clk;
    logic                                  reset;
    logic [NUM_PE-1:0]                     req;
    gnn_bus_pkg::req_kind_e  [NUM_PE-1:0]  req_kind;
    gnn_bus_pkg::node_id_t   [NUM_PE-1:0]  req_node;
    gnn_bus_pkg::pe_tag_t    [NUM_PE-1:0]  req_tag;
    logic [NUM_PE-1:0]                     grant;
    logic                                  nbr_wr_en;
    logic                                  fv_wr_en;
    gnn_bus_pkg::node_id_t                 wr_addr;
    gnn_bus_pkg::info_data_t               wr_data;
    logic                                  nbr_rsp_valid;
    gnn_bus_pkg::info_data_t               nbr_rsp_data;
    gnn_bus_pkg::pe_tag_t                  nbr_rsp_tag;
    logic                                  fv_rsp_valid;
    gnn_bus_pkg::info_data_t               fv_rsp_data;
    gnn_bus_pkg::pe_tag_t                  fv_rsp_tag;

    // raw tests file with six columns per line
    logic [15:0]             tests_mem [MAX_LINES*COLS];
    int                      n_lines;
    int                      last_cycle;
    int                      errors;
    int                      cyc;

    // model of both tables, rr pointer and expected grant
    gnn_bus_pkg::info_data_t model_tbl [2][DEPTH];
    int                      model_ptr;
    logic [NUM_PE-1:0]       exp_grant;
    int                      pe_line [NUM_PE];

    // waiting for the table read, then for the response
    pend_t                   read_q[$];
    pend_t                   rsp_q[$];

    gnn_bus_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .req_kind      (req_kind),
        .req_node      (req_node),
        .req_tag       (req_tag),
        .grant         (grant),
        .nbr_wr_en     (nbr_wr_en),
        .fv_wr_en      (fv_wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .nbr_rsp_valid (nbr_rsp_valid),
        .nbr_rsp_data  (nbr_rsp_data),
        .nbr_rsp_tag   (nbr_rsp_tag),
        .fv_rsp_valid  (fv_rsp_valid),
        .fv_rsp_data   (fv_rsp_data),
        .fv_rsp_tag    (fv_rsp_tag)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic bit [31:0] xorshift(input bit [31:0] x);
        bit [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] test_field(input int line, input int col);
        return tests_mem[line*COLS + col];
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_grant(input logic [NUM_PE-1:0] got, input logic [NUM_PE-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail grant: got %h expected %h in cycle %0d",
                got, exp, cyc));
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got %h expected %h in cycle %0d",
                name, got, exp, cyc));
        end
    endtask

    task automatic check_rsp_data(input string name, input gnn_bus_pkg::info_data_t got,
                                  input gnn_bus_pkg::info_data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got %h expected %h in cycle %0d",
                name, got, exp, cyc));
        end
    endtask

    task automatic check_rsp_tag(input string name, input gnn_bus_pkg::pe_tag_t got,
                                 input gnn_bus_pkg::pe_tag_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got %h expected %h in cycle %0d",
                name, got, exp, cyc));
        end
    endtask

    // one falling edge to check, capture reads, drop, write, raise and arbitrate
    task automatic run_cycle();
        pend_t             ent;
        int                p;
        int                base;
        int                c;
        int                tsel;
        logic              is_fv;
        logic [15:0]       fld;
        logic [NUM_PE-1:0] eligible;
        check_grant(grant, exp_grant);
        p = 0;
        for (int i = 0; i < NUM_PE; i++) begin
            if (exp_grant[i]) begin
                p = i;
            end
        end
        // granted request joins the pipeline with its response two cycles on
        if (exp_grant != '0) begin
            if (int'(test_field(pe_line[p], 5)) != cyc) begin
                report_failure($sformatf("PE %0d was granted in cycle %0d, tests file says %0d",
                    p, cyc, int'(test_field(pe_line[p], 5))));
            end
            ent.kind = req_kind[p];
            ent.node = req_node[p];
            ent.tag  = req_tag[p];
            ent.data = '0;
            ent.due  = cyc + 2;
            read_q.push_back(ent);
        end
        if (rsp_q.size() > 0 && rsp_q[0].due == cyc) begin
            ent   = rsp_q.pop_front();
            is_fv = (ent.kind == gnn_bus_pkg::kind_feature);
            // only the matching port may answer
            check_valid("nbr_rsp_valid", nbr_rsp_valid, !is_fv);
            check_valid("fv_rsp_valid", fv_rsp_valid, is_fv);
            if (is_fv) begin
                check_rsp_data("fv_rsp_data", fv_rsp_data, ent.data);
                check_rsp_tag("fv_rsp_tag", fv_rsp_tag, ent.tag);
            end else begin
                check_rsp_data("nbr_rsp_data", nbr_rsp_data, ent.data);
                check_rsp_tag("nbr_rsp_tag", nbr_rsp_tag, ent.tag);
            end
        end else begin
            check_valid("nbr_rsp_valid", nbr_rsp_valid, 1'b0);
            check_valid("fv_rsp_valid", fv_rsp_valid, 1'b0);
        end
        // table read at the next edge lands before this cycle's write
        if (read_q.size() > 0 && read_q[0].due == cyc + 1) begin
            ent      = read_q.pop_front();
            ent.data = model_tbl[int'(ent.kind)][ent.node];
            rsp_q.push_back(ent);
        end
        // PE lets go once it sees its grant
        req       = req & ~grant;
        nbr_wr_en = 1'b0;
        fv_wr_en  = 1'b0;
        for (int k = 0; k < n_lines; k++) begin
            if (int'(test_field(k, 1)) == cyc && test_field(k, 0) == OP_WRITE) begin
                tsel      = (test_field(k, 2) == 16'h0) ? 0 : 1;
                nbr_wr_en = (tsel == 0);
                fv_wr_en  = (tsel == 1);
                wr_addr   = gnn_bus_pkg::node_id_t'(test_field(k, 3));
                wr_data   = gnn_bus_pkg::info_data_t'(test_field(k, 4));
                model_tbl[tsel][wr_addr] = wr_data;
            end else if (int'(test_field(k, 1)) == cyc && test_field(k, 0) == OP_REQ) begin
                p = int'(test_field(k, 2));
                if (req[p]) begin
                    report_failure("tests file raises a request for a PE that still holds one");
                end
                fld         = test_field(k, 4);
                req[p]      = 1'b1;
                req_kind[p] = gnn_bus_pkg::req_kind_e'(fld[0]);
                req_node[p] = gnn_bus_pkg::node_id_t'(test_field(k, 3));
                req_tag[p]  = gnn_bus_pkg::pe_tag_t'(p);
                pe_line[p]  = k;
            end
        end
        // model arbiter where the current grant holder sits out
        eligible  = req & ~exp_grant;
        exp_grant = '0;
        base      = model_ptr;
        for (int k = 0; k < NUM_PE; k++) begin
            c = (base + k) % NUM_PE;
            if (exp_grant == '0 && eligible[c]) begin
                exp_grant[c] = 1'b1;
                model_ptr    = (c + 1) % NUM_PE;
            end
        end
    endtask

    // watchdog sized from the tests file
    initial begin
        int limit;
        wait (n_lines > 0);
        limit = (n_lines * 20 + 2 * DEPTH + 50) * 4;
        #(limit);
        $display("run timed out before every request was answered");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin
        bit [31:0] rnd;
        int        line;
        int        tsel;
        reset     = 1'b1;
        req       = '0;
        req_kind  = {NUM_PE{gnn_bus_pkg::kind_neighbor}};
        req_node  = '0;
        req_tag   = '0;
        nbr_wr_en = 1'b0;
        fv_wr_en  = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        errors    = 0;
        cyc       = 0;
        model_ptr = 0;
        exp_grant = '0;
        for (int k = 0; k < MAX_LINES * COLS; k++) begin
            tests_mem[k] = OP_END;
        end
        $readmemh("bench/gnn_bus_tests.txt", tests_mem);
        line = 0;
        while (line < MAX_LINES && test_field(line, 0) != OP_END) begin
            line++;
        end
        if (line == 0) begin
            report_failure("tests file holds no test lines");
        end
        n_lines = line;
        // random fill of both tables mixed with the address
        rnd = 32'd18;
        for (int t = 0; t < 2; t++) begin
            for (int a = 0; a < DEPTH; a++) begin
                rnd = xorshift(rnd);
                model_tbl[t][a] = rnd[15:0] ^ {t[0], 3'b000, a[5:0], a[5:0]};
            end
        end
        last_cycle = 0;
        for (int k = 0; k < n_lines; k++) begin
            tsel = (test_field(k, 2) == 16'h0) ? 0 : 1;
            if (test_field(k, 0) == OP_LOAD) begin
                model_tbl[tsel][test_field(k, 3)] = gnn_bus_pkg::info_data_t'(test_field(k, 4));
            end else if (int'(test_field(k, 1)) > last_cycle) begin
                last_cycle = int'(test_field(k, 1));
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // load both tables through the write port
        for (int t = 0; t < 2; t++) begin
            for (int a = 0; a < DEPTH; a++) begin
                @(negedge clk);
                nbr_wr_en = (t == 0);
                fv_wr_en  = (t == 1);
                wr_addr   = gnn_bus_pkg::node_id_t'(a);
                wr_data   = model_tbl[t][a];
            end
        end
        @(negedge clk);
        nbr_wr_en = 1'b0;
        fv_wr_en  = 1'b0;
        // run until every request is granted and answered
        while (cyc <= last_cycle || req != '0 || read_q.size() > 0 || rsp_q.size() > 0) begin
            @(negedge clk);
            run_cycle();
            cyc++;
        end
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/gnn_bus_tests.txt ====
// columns: op cycle sel addr value expect, all hex; op 1 table load, 2 request, 3 timed write, f end
// load and write: sel is table (0 neighbor, 1 feature); request: sel is PE, addr node, value kind, expect grant cycle
1 00 0 05 a505 00
1 00 1 05 5f05 00
1 00 1 07 f007 00
1 00 0 07 7a07 00
1 00 0 10 1010 00
1 00 1 20 2020 00
// single neighbor request, then a single feature request
2 01 2 05 0 02
2 06 1 07 1 07
// grant to PE 3 brings the pointer back to PE 0
2 0a 3 0c 0 0b
// all four at once, served 0 1 2 3
2 0e 0 01 0 0f
2 0e 1 02 1 10
2 0e 2 03 1 11
2 0e 3 04 0 12
// grant to PE 1, then all four again, served 2 3 0 1
2 16 1 06 1 17
2 19 0 08 1 1c
2 19 1 09 0 1d
2 19 2 0a 0 1a
2 19 3 0b 1 1b
// write then read returns the new word
3 21 0 10 beef 00
2 23 0 10 0 24
// write on the read edge returns the old word, a later read the new one
2 28 3 20 1 29
3 2a 1 20 1234 00
2 2d 2 20 1 2e
f 00 0 00 0000 00

// ==== project.f ====
+incdir+src
src/gnn_bus_pkg.sv
src/rr_arbiter.sv
src/bus_arbiter.sv
src/info_mem_cntl.sv
src/gnn_bus_top.sv
bench/gnn_bus_tb.sv

// ==== Makefile ====
# Verilator build and run of the gnn request bus testbench

TOP = gnn_bus_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o $(TOP)

# pass only when the simulation prints the pass message
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
